/* common/lsq_pkg.sv */
package lsq_pkg;

   // data and address words share one width
   localparam int data_w    = 32;
   localparam int offset_w  = 16;
   localparam int tag_w     = 6;

   // number of slots in the in-order load/store queue
   localparam int lsq_depth = 4;

   // word-addressed data memory, byte address bits 9:2 pick the word
   localparam int mem_words = 256;
   localparam int mem_aw    = $clog2(mem_words);

   // a load needs no rt operand, a store needs both
   localparam logic op_load  = 1'b1;
   localparam logic op_store = 1'b0;

   // the immediate offset is signed, so negative offsets reach below the base
   function automatic logic [data_w-1:0] sext_offset(input logic [offset_w-1:0] off);
      return {{(data_w - offset_w){off[offset_w-1]}}, off};
   endfunction

endpackage

/* lsq/lsq_slot.sv */
`timescale 1ns/100ps

module lsq_slot
   import lsq_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,

   input  logic                shift_in,
   input  logic                drop,

   input  logic                up_valid,
   input  logic                up_opcode,
   input  logic [offset_w-1:0] up_offset,
   input  logic [tag_w-1:0]    up_rstag,
   input  logic [tag_w-1:0]    up_rttag,
   input  logic [data_w-1:0]   up_rsdata,
   input  logic [data_w-1:0]   up_rtdata,
   input  logic                up_rsvalid,
   input  logic                up_rtvalid,
   input  logic [data_w-1:0]   up_addr,

   input  logic                cdb_valid,
   input  logic [tag_w-1:0]    cdb_tag,
   input  logic [data_w-1:0]   cdb_data,

   output logic                valid,
   output logic                opcode,
   output logic [offset_w-1:0] offset,
   output logic [tag_w-1:0]    rstag,
   output logic [tag_w-1:0]    rttag,
   output logic [data_w-1:0]   rsdata,
   output logic [data_w-1:0]   rtdata,
   output logic                rsvalid,
   output logic                rtvalid,
   output logic [data_w-1:0]   addr,
   output logic                ready
);

   logic                sel_opcode;
   logic [offset_w-1:0] sel_offset;
   logic [tag_w-1:0]    sel_rstag;
   logic [tag_w-1:0]    sel_rttag;
   logic [data_w-1:0]   sel_rsdata;
   logic [data_w-1:0]   sel_rtdata;
   logic                sel_rsvalid;
   logic                sel_rtvalid;
   logic [data_w-1:0]   sel_addr;
   logic                rs_hit;
   logic                rt_hit;

   // the entry seen by this slot is either the one above (shift) or its own
   assign sel_opcode  = shift_in ? up_opcode  : opcode;
   assign sel_offset  = shift_in ? up_offset  : offset;
   assign sel_rstag   = shift_in ? up_rstag   : rstag;
   assign sel_rttag   = shift_in ? up_rttag   : rttag;
   assign sel_rsdata  = shift_in ? up_rsdata  : rsdata;
   assign sel_rtdata  = shift_in ? up_rtdata  : rtdata;
   assign sel_rsvalid = shift_in ? up_rsvalid : rsvalid;
   assign sel_rtvalid = shift_in ? up_rtvalid : rtvalid;
   assign sel_addr    = shift_in ? up_addr    : addr;

   // snoop the CDB for whichever entry ends up here after the edge
   assign rs_hit = cdb_valid & ~sel_rsvalid & (cdb_tag == sel_rstag);
   // for a load rttag is the destination, so only a store waits on rt
   assign rt_hit = cdb_valid & ~sel_rtvalid & (sel_opcode == op_store) &
                   (cdb_tag == sel_rttag);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid   <= 1'b0;
         rsvalid <= 1'b0;
         rtvalid <= 1'b0;
      end else begin
         // an entry that moved down or issued leaves this slot empty
         valid   <= shift_in ? up_valid : (valid & ~drop);
         rsvalid <= sel_rsvalid | rs_hit;
         rtvalid <= sel_rtvalid | rt_hit;
      end
   end

   always_ff @(posedge clk) begin
      opcode <= sel_opcode;
      offset <= sel_offset;
      rstag  <= sel_rstag;
      rttag  <= sel_rttag;
      rsdata <= rs_hit ? cdb_data : sel_rsdata;
      rtdata <= rt_hit ? cdb_data : sel_rtdata;
      // the address is rebuilt from the broadcast base at the same edge
      addr   <= rs_hit ? (cdb_data + sext_offset(sel_offset)) : sel_addr;
   end

   // operands complete, loads ignore rt
   assign ready = rsvalid & (rtvalid | (opcode == op_load));

endmodule

/* lsq/lsq_queue.sv */
`timescale 1ns/100ps

module lsq_queue
   import lsq_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,

   input  logic                dispatch_opcode,
   input  logic [offset_w-1:0] dispatch_offset,
   input  logic [tag_w-1:0]    dispatch_rstag,
   input  logic [tag_w-1:0]    dispatch_rttag,
   input  logic [data_w-1:0]   dispatch_rsdata,
   input  logic [data_w-1:0]   dispatch_rtdata,
   input  logic                dispatch_rsvalid,
   input  logic                dispatch_rtvalid,
   input  logic                dispatch_en,
   output logic                dispatch_ready,

   input  logic                cdb_valid,
   input  logic [tag_w-1:0]    cdb_tag,
   input  logic [data_w-1:0]   cdb_data,

   output logic                issue_ready,
   output logic                issue_opcode,
   output logic [tag_w-1:0]    issue_tag,
   output logic [data_w-1:0]   issue_addr,
   output logic [data_w-1:0]   issue_data,
   input  logic                issue_done
);

   // index lsq_depth is the incoming stage, built from dispatch without flops
   logic [lsq_depth:0]   q_valid;
   logic                 q_opcode  [lsq_depth+1];
   logic [offset_w-1:0]  q_offset  [lsq_depth+1];
   logic [tag_w-1:0]     q_rstag   [lsq_depth+1];
   logic [tag_w-1:0]     q_rttag   [lsq_depth+1];
   logic [data_w-1:0]    q_rsdata  [lsq_depth+1];
   logic [data_w-1:0]    q_rtdata  [lsq_depth+1];
   logic                 q_rsvalid [lsq_depth+1];
   logic                 q_rtvalid [lsq_depth+1];
   logic [data_w-1:0]    q_addr    [lsq_depth+1];
   logic [lsq_depth-1:0] q_ready;

   logic [lsq_depth-1:0] shift;
   logic [lsq_depth-1:0] drop;
   logic                 take;
   logic                 in_rs_hit;
   logic                 in_rt_hit;

   // a broadcast in the dispatch cycle resolves the incoming operands directly
   assign in_rs_hit = cdb_valid & ~dispatch_rsvalid & (cdb_tag == dispatch_rstag);
   assign in_rt_hit = cdb_valid & ~dispatch_rtvalid & (dispatch_opcode == op_store) &
                      (cdb_tag == dispatch_rttag);

   assign q_valid[lsq_depth]   = dispatch_en;
   assign q_opcode[lsq_depth]  = dispatch_opcode;
   assign q_offset[lsq_depth]  = dispatch_offset;
   assign q_rstag[lsq_depth]   = dispatch_rstag;
   assign q_rttag[lsq_depth]   = dispatch_rttag;
   assign q_rsdata[lsq_depth]  = in_rs_hit ? cdb_data : dispatch_rsdata;
   assign q_rtdata[lsq_depth]  = in_rt_hit ? cdb_data : dispatch_rtdata;
   assign q_rsvalid[lsq_depth] = dispatch_rsvalid | in_rs_hit;
   assign q_rtvalid[lsq_depth] = dispatch_rtvalid | in_rt_hit;
   assign q_addr[lsq_depth]    = q_rsdata[lsq_depth] + sext_offset(dispatch_offset);

   // only the head may issue, so memory operations stay in program order
   assign issue_ready  = q_valid[0] & q_ready[0];
   assign issue_opcode = q_opcode[0];
   assign issue_tag    = q_rttag[0];
   assign issue_addr   = q_addr[0];
   assign issue_data   = q_rtdata[0];

   assign take = issue_ready & issue_done;

   always_comb begin
      logic hole;
      hole = 1'b0;
      for (int i = 0; i < lsq_depth; i++) begin
         // a slot pulls from above when anything at or below it frees up
         hole     = hole | ~q_valid[i];
         shift[i] = q_valid[i+1] & (take | hole);
         // the old entry leaves when it issues or moves one slot down
         drop[i]  = (i == 0) ? take : shift[i-1];
      end
   end

   // full only when every slot is busy and the head is not leaving
   assign dispatch_ready = ~(&q_valid[lsq_depth-1:0] & ~take);

   for (genvar i = 0; i < lsq_depth; i++) begin : g_slot
      lsq_slot slot_i (
         .clk        (clk),
         .rst_n      (rst_n),
         .shift_in   (shift[i]),
         .drop       (drop[i]),
         .up_valid   (q_valid[i+1]),
         .up_opcode  (q_opcode[i+1]),
         .up_offset  (q_offset[i+1]),
         .up_rstag   (q_rstag[i+1]),
         .up_rttag   (q_rttag[i+1]),
         .up_rsdata  (q_rsdata[i+1]),
         .up_rtdata  (q_rtdata[i+1]),
         .up_rsvalid (q_rsvalid[i+1]),
         .up_rtvalid (q_rtvalid[i+1]),
         .up_addr    (q_addr[i+1]),
         .cdb_valid  (cdb_valid),
         .cdb_tag    (cdb_tag),
         .cdb_data   (cdb_data),
         .valid      (q_valid[i]),
         .opcode     (q_opcode[i]),
         .offset     (q_offset[i]),
         .rstag      (q_rstag[i]),
         .rttag      (q_rttag[i]),
         .rsdata     (q_rsdata[i]),
         .rtdata     (q_rtdata[i]),
         .rsvalid    (q_rsvalid[i]),
         .rtvalid    (q_rtvalid[i]),
         .addr       (q_addr[i]),
         .ready      (q_ready[i])
      );

      // an occupied slot takes a new entry only when its own entry leaves
      a_no_overwrite : assert property (@(posedge clk) disable iff (!rst_n)
         shift[i] |-> (!q_valid[i] || drop[i]));
   end

   // an offered head entry waits unchanged until the memory unit takes it
   a_issue_hold : assert property (@(posedge clk) disable iff (!rst_n)
      (issue_ready && !issue_done) |=> (issue_ready && $stable(issue_tag) &&
                                        $stable(issue_addr) && $stable(issue_data)));

   // a dispatch while full would be taken by the top slot and lost
   a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
      (dispatch_en && !dispatch_ready) |-> !shift[lsq_depth-1]);

endmodule

/* source/ls_mem_unit.sv */
`timescale 1ns/100ps

module ls_mem_unit
   import lsq_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,

   input  logic              issue_ready,
   input  logic              issue_opcode,
   input  logic [tag_w-1:0]  issue_tag,
   input  logic [data_w-1:0] issue_addr,
   input  logic [data_w-1:0] issue_data,
   output logic              issue_done,

   output logic              ld_valid,
   output logic [tag_w-1:0]  ld_tag,
   output logic [data_w-1:0] ld_data,
   input  logic              ld_grant
);

   logic [data_w-1:0] mem [mem_words];
   logic [mem_aw-1:0] word_idx;
   logic              xfer;

   // byte address, word aligned
   assign word_idx = issue_addr[mem_aw+1:2];

   // the result register must drain before another operation is taken
   assign issue_done = ~ld_valid | ld_grant;
   assign xfer       = issue_ready & issue_done;

   always_ff @(posedge clk) begin
      if (xfer && issue_opcode == op_store) begin
         mem[word_idx] <= issue_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ld_valid <= 1'b0;
      end else if (xfer && issue_opcode == op_load) begin
         ld_valid <= 1'b1;
      end else if (ld_grant) begin
         ld_valid <= 1'b0;
      end
   end

   // load data and destination tag wait here until the arbiter grants them
   always_ff @(posedge clk) begin
      if (xfer && issue_opcode == op_load) begin
         ld_tag  <= issue_tag;
         ld_data <= mem[word_idx];
      end
   end

   // a held result stays put until it has gone out on the CDB
   a_ld_hold : assert property (@(posedge clk) disable iff (!rst_n)
      (ld_valid && !ld_grant) |=> (ld_valid && $stable(ld_tag) && $stable(ld_data)));

endmodule

/* source/cdb_arbiter.sv */
`timescale 1ns/100ps

module cdb_arbiter
   import lsq_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,

   input  logic              ld_valid,
   input  logic [tag_w-1:0]  ld_tag,
   input  logic [data_w-1:0] ld_data,
   output logic              ld_grant,

   input  logic              ext_valid,
   input  logic [tag_w-1:0]  ext_tag,
   input  logic [data_w-1:0] ext_data,
   output logic              ext_ready,

   output logic              cdb_valid,
   output logic [tag_w-1:0]  cdb_tag,
   output logic [data_w-1:0] cdb_data
);

   logic              hold_valid;
   logic [tag_w-1:0]  hold_tag;
   logic [data_w-1:0] hold_data;
   logic              ext_grant;
   logic              last_ld;

   // when both wait, the source that lost last time goes first
   assign ld_grant  = ld_valid & (~hold_valid | ~last_ld);
   assign ext_grant = hold_valid & ~ld_grant;

   // the holding slot frees up in the same cycle it is granted
   assign ext_ready = ~hold_valid | ext_grant;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hold_valid <= 1'b0;
         last_ld    <= 1'b0;
         cdb_valid  <= 1'b0;
      end else begin
         if (ext_valid && ext_ready) begin
            hold_valid <= 1'b1;
         end else if (ext_grant) begin
            hold_valid <= 1'b0;
         end
         if (ld_grant || ext_grant) begin
            last_ld <= ld_grant;
         end
         cdb_valid <= ld_grant | ext_grant;
      end
   end

   always_ff @(posedge clk) begin
      if (ext_valid && ext_ready) begin
         hold_tag  <= ext_tag;
         hold_data <= ext_data;
      end
      cdb_tag  <= ld_grant ? ld_tag  : hold_tag;
      cdb_data <= ld_grant ? ld_data : hold_data;
   end

   // a held external result loses at most once before it goes out
   a_ext_turn : assert property (@(posedge clk) disable iff (!rst_n)
      (hold_valid && !ext_grant) |=> ext_grant);

endmodule

/* source/ls_subsystem_top.sv */
`timescale 1ns/100ps

module ls_subsystem_top
   import lsq_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,

   input  logic                dispatch_opcode,
   input  logic [offset_w-1:0] dispatch_offset,
   input  logic [tag_w-1:0]    dispatch_rstag,
   input  logic [tag_w-1:0]    dispatch_rttag,
   input  logic [data_w-1:0]   dispatch_rsdata,
   input  logic [data_w-1:0]   dispatch_rtdata,
   input  logic                dispatch_rsvalid,
   input  logic                dispatch_rtvalid,
   input  logic                dispatch_en,
   output logic                dispatch_ready,

   input  logic                ext_valid,
   input  logic [tag_w-1:0]    ext_tag,
   input  logic [data_w-1:0]   ext_data,
   output logic                ext_ready,

   output logic                cdb_valid,
   output logic [tag_w-1:0]    cdb_tag,
   output logic [data_w-1:0]   cdb_data
);

   logic              issue_ready;
   logic              issue_opcode;
   logic [tag_w-1:0]  issue_tag;
   logic [data_w-1:0] issue_addr;
   logic [data_w-1:0] issue_data;
   logic              issue_done;
   logic              ld_valid;
   logic [tag_w-1:0]  ld_tag;
   logic [data_w-1:0] ld_data;
   logic              ld_grant;

   lsq_queue lsq_queue_i (
      .clk              (clk),
      .rst_n            (rst_n),
      .dispatch_opcode  (dispatch_opcode),
      .dispatch_offset  (dispatch_offset),
      .dispatch_rstag   (dispatch_rstag),
      .dispatch_rttag   (dispatch_rttag),
      .dispatch_rsdata  (dispatch_rsdata),
      .dispatch_rtdata  (dispatch_rtdata),
      .dispatch_rsvalid (dispatch_rsvalid),
      .dispatch_rtvalid (dispatch_rtvalid),
      .dispatch_en      (dispatch_en),
      .dispatch_ready   (dispatch_ready),
      .cdb_valid        (cdb_valid),
      .cdb_tag          (cdb_tag),
      .cdb_data         (cdb_data),
      .issue_ready      (issue_ready),
      .issue_opcode     (issue_opcode),
      .issue_tag        (issue_tag),
      .issue_addr       (issue_addr),
      .issue_data       (issue_data),
      .issue_done       (issue_done)
   );

   ls_mem_unit ls_mem_unit_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .issue_ready  (issue_ready),
      .issue_opcode (issue_opcode),
      .issue_tag    (issue_tag),
      .issue_addr   (issue_addr),
      .issue_data   (issue_data),
      .issue_done   (issue_done),
      .ld_valid     (ld_valid),
      .ld_tag       (ld_tag),
      .ld_data      (ld_data),
      .ld_grant     (ld_grant)
   );

   // load results share the CDB with the core's other execution units
   cdb_arbiter cdb_arbiter_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .ld_valid  (ld_valid),
      .ld_tag    (ld_tag),
      .ld_data   (ld_data),
      .ld_grant  (ld_grant),
      .ext_valid (ext_valid),
      .ext_tag   (ext_tag),
      .ext_data  (ext_data),
      .ext_ready (ext_ready),
      .cdb_valid (cdb_valid),
      .cdb_tag   (cdb_tag),
      .cdb_data  (cdb_data)
   );

endmodule

/* bench/tb_ls_subsystem.sv */
`timescale 1ns/100ps

module tb_ls_subsystem
   import lsq_pkg::*;
();

   logic                clk;
   logic                rst_n;
   logic                dispatch_opcode;
   logic [offset_w-1:0] dispatch_offset;
   logic [tag_w-1:0]    dispatch_rstag;
   logic [tag_w-1:0]    dispatch_rttag;
   logic [data_w-1:0]   dispatch_rsdata;
   logic [data_w-1:0]   dispatch_rtdata;
   logic                dispatch_rsvalid;
   logic                dispatch_rtvalid;
   logic                dispatch_en;
   logic                dispatch_ready;
   logic                ext_valid;
   logic [tag_w-1:0]    ext_tag;
   logic [data_w-1:0]   ext_data;
   logic                ext_ready;
   logic                cdb_valid;
   logic [tag_w-1:0]    cdb_tag;
   logic [data_w-1:0]   cdb_data;

   // model memory covers the 32 words that the stimulus touches
   logic [31:0]         lfsr = 32'h8856;
   logic [data_w-1:0]   model_mem [32];
   // per tag the value that must show up on the CDB, and whether it is a load
   logic [data_w-1:0]   exp_data [2**tag_w];
   logic                is_load [2**tag_w];
   // a tag is in flight while its posted and seen bits differ
   logic [2**tag_w-1:0] posted;
   logic [2**tag_w-1:0] seen;
   logic [tag_w-1:0]    next_tag;
   logic [tag_w-1:0]    ld_ring [16];
   logic [3:0]          ld_head;
   logic [3:0]          ld_tail;
   // results waiting to be sent through the external port
   logic [tag_w-1:0]    xq_tag [64];
   logic [data_w-1:0]   xq_data [64];
   logic [5:0]          xq_rd;
   logic [5:0]          xq_wr;
   logic                stim_done;
   logic                full_hold;
   int                  errors;
   int                  timeouts;
   int                  results;
   int                  ext_wait;
   int                  ld_wait;

   ls_subsystem_top ls_subsystem_top_i (.*);

   always #4 clk = ~clk;

   // Galois LFSR, one step for every bit handed out
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic coin();
      logic [31:0] r;
      r = rand_bits(1);
      return r[0];
   endfunction

   function automatic void flag_error(input string msg);
      errors = errors + 1;
      $display("FAIL %0t: %s", $time, msg);
   endfunction

   // hand out the next free tag and record what its broadcast must carry
   function automatic logic [tag_w-1:0] alloc_tag(input logic [data_w-1:0] value,
                                                  input logic load);
      logic [tag_w-1:0] tag;
      for (int i = 0; i < 2**tag_w; i++) begin
         if (posted[next_tag] == seen[next_tag]) break;
         next_tag = next_tag + 1'b1;
      end
      tag           = next_tag;
      exp_data[tag] = value;
      is_load[tag]  = load;
      posted[tag]   = ~posted[tag];
      next_tag      = next_tag + 1'b1;
      if (load) begin
         // loads leave the memory unit in program order
         ld_ring[ld_tail] = tag;
         ld_tail          = ld_tail + 1'b1;
      end
      return tag;
   endfunction

   function automatic void push_ext(input logic [tag_w-1:0] tag, input logic [data_w-1:0] d);
      xq_tag[xq_wr]  = tag;
      xq_data[xq_wr] = d;
      xq_wr          = xq_wr + 1'b1;
   endfunction

   task automatic send_ext(input logic [tag_w-1:0] tag, input logic [data_w-1:0] d);
      int t;
      @(posedge clk);
      ext_valid <= 1'b1;
      ext_tag   <= tag;
      ext_data  <= d;
      for (t = 0; t < 20; t++) begin
         @(negedge clk);
         if (ext_ready) break;
      end
      if (t == 20) begin
         timeouts = timeouts + 1;
         $display("timeout: external result %0d was never accepted", tag);
      end
      // the result is taken at this edge
      @(posedge clk);
      ext_valid <= 1'b0;
   endtask

   task automatic dispatch(input logic op, input logic [offset_w-1:0] off,
                           input logic [tag_w-1:0] rs_t, input logic [tag_w-1:0] rt_t,
                           input logic [data_w-1:0] rs_d, input logic [data_w-1:0] rt_d,
                           input logic rs_v, input logic rt_v);
      int t;
      @(posedge clk);
      dispatch_opcode  <= op;
      dispatch_offset  <= off;
      dispatch_rstag   <= rs_t;
      dispatch_rttag   <= rt_t;
      dispatch_rsdata  <= rs_d;
      dispatch_rtdata  <= rt_d;
      dispatch_rsvalid <= rs_v;
      dispatch_rtvalid <= rt_v;
      dispatch_en      <= 1'b1;
      for (t = 0; t < 200; t++) begin
         @(negedge clk);
         if (dispatch_ready) break;
      end
      if (t == 200) begin
         timeouts = timeouts + 1;
         $display("timeout: the queue never accepted an instruction");
      end
      @(posedge clk);
      dispatch_en <= 1'b0;
   endtask

   // rs_mode 0 gives a ready base, 1 a base broadcast later, 2 one broadcast in the
   // dispatch cycle itself
   task automatic mem_op(input logic op, input logic [4:0] w, input logic [1:0] rs_mode,
                         input logic rt_pend, input logic [data_w-1:0] val);
      logic [offset_w-1:0] off;
      logic [data_w-1:0]   base;
      logic [tag_w-1:0]    rs_t;
      logic [tag_w-1:0]    rt_t;
      off  = offset_w'(rand_bits(offset_w));
      // pick the base so that base plus the signed offset hits word w
      base = {25'd0, w, 2'b00} - {{(data_w - offset_w){off[offset_w-1]}}, off};
      rs_t = '0;
      rt_t = '0;
      if (rs_mode != 2'd0) rs_t = alloc_tag(base, 1'b0);
      if (op == op_store) begin
         if (rt_pend) rt_t = alloc_tag(val, 1'b0);
         model_mem[w] = val;
      end else begin
         rt_t = alloc_tag(model_mem[w], 1'b1);
      end
      if (rs_mode == 2'd2) send_ext(rs_t, base);
      // pending operands carry garbage that the CDB has to replace
      dispatch(op, off, rs_t, rt_t, (rs_mode != 2'd0) ? ~base : base,
               (op == op_store && rt_pend) ? ~val : val, rs_mode == 2'd0,
               op == op_load || !rt_pend);
      if (rs_mode == 2'd1) push_ext(rs_t, base);
      if (op == op_store && rt_pend) push_ext(rt_t, val);
   endtask

   task automatic ext_driver();
      int guard;
      for (guard = 0; guard < 5000; guard++) begin
         if (stim_done && xq_rd == xq_wr) break;
         if (xq_rd != xq_wr) begin
            repeat (rand_bits(2)) @(posedge clk);
            send_ext(xq_tag[xq_rd], xq_data[xq_rd]);
            xq_rd = xq_rd + 1'b1;
         end else begin
            @(posedge clk);
         end
      end
      if (guard == 5000) begin
         timeouts = timeouts + 1;
         $display("timeout: external results were still queued");
      end
   endtask

   task automatic drain();
      int t;
      for (t = 0; t < 400; t++) begin
         @(negedge clk);
         if (posted == seen) break;
      end
      if (t == 400) begin
         timeouts = timeouts + 1;
         $display("timeout: expected results never reached the CDB");
      end
   endtask

   // bookkeeping of what went out on the CDB, and how long each source waited
   always @(posedge clk) begin
      if (!rst_n) begin
         seen     <= '0;
         ld_head  <= '0;
         ext_wait <= 0;
         ld_wait  <= 0;
      end else begin
         if (cdb_valid) begin
            seen[cdb_tag] <= ~seen[cdb_tag];
            results       <= results + 1;
            if (is_load[cdb_tag]) ld_head <= ld_head + 1'b1;
         end
         ext_wait <= (ext_valid && !ext_ready) ? ext_wait + 1 : 0;
         ld_wait  <= (ls_subsystem_top_i.ld_valid && !ls_subsystem_top_i.ld_grant) ?
                     ld_wait + 1 : 0;
      end
   end

   a_reset_state : assert property (@(posedge clk) $rose(rst_n) |-> !cdb_valid && dispatch_ready)
      else flag_error("CDB busy or dispatch blocked right after reset");

   // each broadcast must be one that is owed, and owed only once
   a_tag_owed : assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid |-> posted[cdb_tag] != seen[cdb_tag])
      else flag_error($sformatf("tag %0d on the CDB was not owed", $sampled(cdb_tag)));

   a_cdb_data : assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid |-> cdb_data == exp_data[cdb_tag])
      else flag_error($sformatf("tag %0d carried %h, expected %h", $sampled(cdb_tag),
                                $sampled(cdb_data), exp_data[$sampled(cdb_tag)]));

   a_load_order : assert property (@(posedge clk) disable iff (!rst_n)
      cdb_valid && is_load[cdb_tag] |-> cdb_tag == ld_ring[ld_head])
      else flag_error($sformatf("load tag %0d came out of order", $sampled(cdb_tag)));

   // four blocked entries leave no room, so a fifth must stay out
   a_full : assert property (@(posedge clk) disable iff (!rst_n) full_hold |-> !dispatch_ready)
      else flag_error("dispatch_ready high with four blocked entries");

   a_ext_wait : assert property (@(posedge clk) disable iff (!rst_n) ext_wait < 4)
      else flag_error("external result starved at the arbiter");

   a_ld_wait : assert property (@(posedge clk) disable iff (!rst_n) ld_wait < 3)
      else flag_error("load result starved at the arbiter");

   initial begin
      logic [data_w-1:0] noise;
      logic [4:0]        w;
      clk              = 1'b0;
      rst_n            = 1'b0;
      dispatch_opcode  = 1'b0;
      dispatch_offset  = '0;
      dispatch_rstag   = '0;
      dispatch_rttag   = '0;
      dispatch_rsdata  = '0;
      dispatch_rtdata  = '0;
      dispatch_rsvalid = 1'b0;
      dispatch_rtvalid = 1'b0;
      dispatch_en      = 1'b0;
      ext_valid        = 1'b0;
      ext_tag          = '0;
      ext_data         = '0;
      posted           = '0;
      next_tag         = '0;
      ld_tail          = '0;
      xq_rd            = '0;
      xq_wr            = '0;
      stim_done        = 1'b1;
      full_hold        = 1'b0;
      errors           = 0;
      timeouts         = 0;
      results          = 0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      // fill every word used later with a pattern built from its index
      for (int i = 0; i < 32; i++) begin
         w = 5'(i);
         mem_op(op_store, w, 2'd0, 1'b0, {w, ~w, w, ~w, w, ~w, 2'b10});
      end
      drain();

      // loads whose base arrives on the CDB in the very cycle of dispatch
      for (int i = 0; i < 4; i++) begin
         mem_op(op_load, 5'(rand_bits(5)), 2'd2, 1'b0, '0);
         drain();
      end

      // four loads wait on bases that nobody has broadcast yet
      for (int i = 0; i < 4; i++) begin
         mem_op(op_load, 5'(rand_bits(5)), 2'd1, 1'b0, '0);
      end
      full_hold = 1'b1;
      fork
         mem_op(op_load, 5'(rand_bits(5)), 2'd0, 1'b0, '0);
         begin
            repeat (6) @(posedge clk);
            full_hold = 1'b0;
            ext_driver();
         end
      join
      drain();

      // random mix of loads, stores and unrelated external results
      stim_done = 1'b0;
      fork
         ext_driver();
         begin
            for (int n = 0; n < 80; n++) begin
               mem_op(coin(), 5'(rand_bits(5)), {1'b0, coin()}, coin(), rand_bits(data_w));
               if (coin()) begin
                  noise = rand_bits(data_w);
                  push_ext(alloc_tag(noise, 1'b0), noise);
               end
            end
            stim_done = 1'b1;
         end
      join
      drain();

      repeat (4) @(posedge clk);
      $display("summary: %0d CDB results, %0d errors, %0d timeouts", results, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* vlog.f */
common/lsq_pkg.sv
lsq/lsq_slot.sv
lsq/lsq_queue.sv
source/ls_mem_unit.sv
source/cdb_arbiter.sv
source/ls_subsystem_top.sv
bench/tb_ls_subsystem.sv

/* run_sim.sh */
#!/bin/bash
# builds the testbench with Verilator, runs it and checks the log for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
   --top-module tb_ls_subsystem -o sim_tb > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q 'All tests passed!' sim.log && echo "simulation ok" \
   || { echo "simulation failed, see sim.log"; exit 1; }
